//--- source/host_bridge_pkg.sv
// shared widths, vector types, AXI channel structs and FSM states; import where used
package host_bridge_pkg;

   // --------------------------------------------------
   // bus widths
   // --------------------------------------------------
   localparam int AXI_ADDR_W = 64;
   localparam int LINE_W     = 512;
   localparam int STRB_W     = 64;
   localparam int WORD_W     = 32;
   localparam int AXI_ID_W   = 6;
   localparam int AXI_LEN_W  = 8;

   typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
   typedef logic [LINE_W-1:0]     line_t;
   typedef logic [STRB_W-1:0]     strb_t;
   typedef logic [WORD_W-1:0]     word_t;
   typedef logic [AXI_ID_W-1:0]   axi_id_t;
   typedef logic [1:0]            axi_resp_t;

   // every bridge transaction uses the same id
   localparam axi_id_t   BRIDGE_AXI_ID = '0;
   localparam axi_resp_t RESP_OKAY     = 2'b00;

   // --------------------------------------------------
   // AXI channels
   // --------------------------------------------------
   typedef struct packed {
      axi_addr_t            addr;
      axi_id_t              id;
      logic [AXI_LEN_W-1:0] len;
   } axi_aw_t;

   typedef struct packed {
      line_t data;
      strb_t strb;
      logic  last;
   } axi_w_t;

   typedef struct packed {
      axi_id_t   id;
      axi_resp_t resp;
   } axi_b_t;

   // read command carries the same fields as a write command
   typedef axi_aw_t axi_ar_t;

   typedef struct packed {
      axi_id_t   id;
      line_t     data;
      axi_resp_t resp;
      logic      last;
   } axi_r_t;

   // pending host access and its result
   typedef struct packed {
      axi_addr_t addr;
      word_t     wdata;
      logic      write;
   } host_req_t;

   typedef struct packed {
      word_t rdata;
      logic  err;
   } host_rsp_t;

   typedef enum logic [1:0] {
      IDLE,
      WRITE,
      READ,
      RESPOND
   } bridge_state_e;

endpackage

//--- source/reset_ctrl.sv
// reset chain, FLR-controlled interface reset and DDR calibration-done synchronizer
`timescale 1ns/1ps

module reset_ctrl #(
   parameter int RST_STAGES   = 5,
   parameter int READY_STAGES = 3
) (
   input  logic clk_out,
   input  logic sync_rst_n,
   input  logic flr_req_i,
   input  logic calib_done_i,
   output logic core_rst_n_o,
   output logic intf_rst_n_o,
   output logic ddr_ready_o
);

   logic [RST_STAGES-1:0]   rst_chain_q;
   logic [READY_STAGES-1:0] ready_sync_q;

   // --------------------------------------------------
   // core reset chain
   // --------------------------------------------------
   // asserts at once, releases after RST_STAGES edges
   always_ff @(posedge clk_out or negedge sync_rst_n) begin
      if (!sync_rst_n) begin
         rst_chain_q <= '0;
      end else begin
         rst_chain_q <= {rst_chain_q[RST_STAGES-2:0], 1'b1};
      end
   end

   assign core_rst_n_o = rst_chain_q[RST_STAGES-1];

   // interface reset, one cycle behind core reset
   // flr request holds it low
   always_ff @(posedge clk_out or negedge core_rst_n_o) begin
      if (!core_rst_n_o) begin
         intf_rst_n_o <= 1'b0;
      end else begin
         intf_rst_n_o <= ~flr_req_i;
      end
   end

   // --------------------------------------------------
   // calibration done synchronizer
   // --------------------------------------------------
   always_ff @(posedge clk_out or negedge core_rst_n_o) begin
      if (!core_rst_n_o) begin
         ready_sync_q <= '0;
      end else begin
         ready_sync_q <= {ready_sync_q[READY_STAGES-2:0], calib_done_i};
      end
   end

   assign ddr_ready_o = ready_sync_q[READY_STAGES-1];

endmodule

//--- source/wb_access_ctrl.sv
// Wishbone classic slave FSM; hands one access to the write or read engine at a time
`timescale 1ns/1ps

module wb_access_ctrl
   import host_bridge_pkg::*;
(
   input  logic          clk_out,
   input  logic          core_rst_n_i,
   // Wishbone slave
   input  logic          wb_cyc_i,
   input  logic          wb_stb_i,
   input  logic          wb_we_i,
   input  axi_addr_t     wb_adr_i,
   input  word_t         wb_dat_i,
   output word_t         wb_dat_o,
   output logic          wb_ack_o,
   output logic          wb_err_o,
   // engine side
   input  logic          wr_done_i,
   input  logic          rd_done_i,
   input  host_rsp_t     wr_rsp_i,
   input  host_rsp_t     rd_rsp_i,
   output host_req_t     req_o,
   output logic          wr_start_o,
   output logic          rd_start_o
);

   bridge_state_e state_q;
   logic          req_seen;
   logic          eng_done;
   host_rsp_t     eng_rsp;

   assign req_seen = wb_cyc_i & wb_stb_i;

   // result of whichever engine owns the access
   assign eng_done = req_o.write ? wr_done_i : rd_done_i;
   assign eng_rsp  = req_o.write ? wr_rsp_i : rd_rsp_i;

   // --------------------------------------------------
   // control FSM
   // --------------------------------------------------
   always_ff @(posedge clk_out or negedge core_rst_n_i) begin
      if (!core_rst_n_i) begin
         state_q    <= IDLE;
         wr_start_o <= 1'b0;
         rd_start_o <= 1'b0;
         wb_ack_o   <= 1'b0;
         wb_err_o   <= 1'b0;
      end else begin
         wr_start_o <= 1'b0;
         rd_start_o <= 1'b0;
         wb_ack_o   <= 1'b0;
         wb_err_o   <= 1'b0;
         case (state_q)
            IDLE: begin
               if (req_seen) begin
                  wr_start_o <= wb_we_i;
                  rd_start_o <= ~wb_we_i;
                  state_q    <= wb_we_i ? WRITE : READ;
               end
            end
            WRITE, READ: begin
               if (eng_done) begin
                  wb_ack_o <= ~eng_rsp.err;
                  wb_err_o <= eng_rsp.err;
                  state_q  <= RESPOND;
               end
            end
            // host drops stb while we sit here
            RESPOND: state_q <= IDLE;
            default: state_q <= IDLE;
         endcase
      end
   end

   // request latch and read data
   always_ff @(posedge clk_out) begin
      if (state_q == IDLE && req_seen) begin
         req_o.addr  <= wb_adr_i;
         req_o.wdata <= wb_dat_i;
         req_o.write <= wb_we_i;
      end
      if (state_q == READ && rd_done_i) begin
         wb_dat_o <= rd_rsp_i.rdata;
      end
   end

endmodule

//--- source/axi_wr_channel.sv
// single-beat AXI write engine; places the host word in its lane and returns bresp status
`timescale 1ns/1ps

module axi_wr_channel
   import host_bridge_pkg::*;
(
   input  logic      clk_out,
   input  logic      core_rst_n_i,
   input  host_req_t req_i,
   input  logic      start_i,
   // AXI write master
   output axi_aw_t   aw_o,
   output logic      aw_valid_o,
   input  logic      aw_ready_i,
   output axi_w_t    w_o,
   output logic      w_valid_o,
   input  logic      w_ready_i,
   input  axi_b_t    b_i,
   input  logic      b_valid_i,
   output logic      bready_o,
   // result
   output logic      done_o,
   output host_rsp_t rsp_o
);

   logic [3:0] word_off;
   logic       b_xfer;

   // word index within the 64 byte line
   assign word_off = req_i.addr[5:2];
   assign b_xfer   = bready_o & b_valid_i;

   // --------------------------------------------------
   // handshake state
   // --------------------------------------------------
   // aw and w drop independently on their own transfer
   always_ff @(posedge clk_out or negedge core_rst_n_i) begin
      if (!core_rst_n_i) begin
         aw_valid_o <= 1'b0;
         w_valid_o  <= 1'b0;
         bready_o   <= 1'b0;
         done_o     <= 1'b0;
      end else begin
         done_o <= 1'b0;
         if (start_i) begin
            aw_valid_o <= 1'b1;
            w_valid_o  <= 1'b1;
            bready_o   <= 1'b1;
         end else begin
            if (aw_valid_o && aw_ready_i) begin
               aw_valid_o <= 1'b0;
            end
            if (w_valid_o && w_ready_i) begin
               w_valid_o <= 1'b0;
            end
            if (b_xfer) begin
               bready_o <= 1'b0;
               done_o   <= 1'b1;
            end
         end
      end
   end

   // payload, stable from start until transfer
   always_ff @(posedge clk_out) begin
      if (start_i) begin
         aw_o.addr <= req_i.addr;
         aw_o.id   <= BRIDGE_AXI_ID;
         aw_o.len  <= '0;
         w_o.data  <= line_t'(req_i.wdata) << (word_off * WORD_W);
         w_o.strb  <= strb_t'(4'hf) << (word_off * 4);
         w_o.last  <= 1'b1;
      end
      if (b_xfer) begin
         rsp_o.rdata <= '0;
         rsp_o.err   <= (b_i.resp != RESP_OKAY);
      end
   end

endmodule

//--- source/axi_rd_channel.sv
// single-beat AXI read engine; picks the addressed word out of the returned line
`timescale 1ns/1ps

module axi_rd_channel
   import host_bridge_pkg::*;
(
   input  logic      clk_out,
   input  logic      core_rst_n_i,
   input  host_req_t req_i,
   input  logic      start_i,
   // AXI read master
   output axi_ar_t   ar_o,
   output logic      ar_valid_o,
   input  logic      ar_ready_i,
   input  axi_r_t    r_i,
   input  logic      r_valid_i,
   output logic      rready_o,
   // result
   output logic      done_o,
   output host_rsp_t rsp_o
);

   logic [3:0] word_off;
   logic       r_xfer;

   // held command address selects the lane
   assign word_off = ar_o.addr[5:2];
   assign r_xfer   = rready_o & r_valid_i;

   // --------------------------------------------------
   // handshake state
   // --------------------------------------------------
   always_ff @(posedge clk_out or negedge core_rst_n_i) begin
      if (!core_rst_n_i) begin
         ar_valid_o <= 1'b0;
         rready_o   <= 1'b0;
         done_o     <= 1'b0;
      end else begin
         done_o <= 1'b0;
         if (start_i) begin
            ar_valid_o <= 1'b1;
            rready_o   <= 1'b1;
         end else begin
            if (ar_valid_o && ar_ready_i) begin
               ar_valid_o <= 1'b0;
            end
            if (r_xfer) begin
               rready_o <= 1'b0;
               done_o   <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk_out) begin
      if (start_i) begin
         ar_o.addr <= req_i.addr;
         ar_o.id   <= BRIDGE_AXI_ID;
         ar_o.len  <= '0;
      end
      // slverr or decerr both count as error
      if (r_xfer) begin
         rsp_o.rdata <= r_i.data[word_off*WORD_W +: WORD_W];
         rsp_o.err   <= (r_i.resp != RESP_OKAY);
      end
   end

endmodule

//--- source/host_bridge_top.sv
// host access bridge top; Wishbone poke/peek in, single-beat AXI bursts out to the CL
`timescale 1ns/1ps

module host_bridge_top
   import host_bridge_pkg::*;
#(
   parameter int RST_STAGES   = 5,
   parameter int READY_STAGES = 3
) (
   input  logic      clk_out,
   input  logic      sync_rst_n,
   input  logic      flr_req_i,
   input  logic      calib_done_i,
   // Wishbone slave
   input  logic      wb_cyc_i,
   input  logic      wb_stb_i,
   input  logic      wb_we_i,
   input  axi_addr_t wb_adr_i,
   input  word_t     wb_dat_i,
   output word_t     wb_dat_o,
   output logic      wb_ack_o,
   output logic      wb_err_o,
   // AXI master to CL
   output axi_aw_t   aw_o,
   output logic      aw_valid_o,
   input  logic      aw_ready_i,
   output axi_w_t    w_o,
   output logic      w_valid_o,
   input  logic      w_ready_i,
   input  axi_b_t    b_i,
   input  logic      b_valid_i,
   output logic      bready_o,
   output axi_ar_t   ar_o,
   output logic      ar_valid_o,
   input  logic      ar_ready_i,
   input  axi_r_t    r_i,
   input  logic      r_valid_i,
   output logic      rready_o,
   // status
   output logic      intf_rst_n_o,
   output logic      ddr_ready_o
);

   logic      core_rst_n;
   host_req_t req;
   logic      wr_start;
   logic      rd_start;
   logic      wr_done;
   logic      rd_done;
   host_rsp_t wr_rsp;
   host_rsp_t rd_rsp;

   reset_ctrl #(
      .RST_STAGES   (RST_STAGES),
      .READY_STAGES (READY_STAGES)
   ) u_reset_ctrl (
      .clk_out      (clk_out),
      .sync_rst_n   (sync_rst_n),
      .flr_req_i    (flr_req_i),
      .calib_done_i (calib_done_i),
      .core_rst_n_o (core_rst_n),
      .intf_rst_n_o (intf_rst_n_o),
      .ddr_ready_o  (ddr_ready_o)
   );

   // --------------------------------------------------
   // host side
   // --------------------------------------------------
   wb_access_ctrl u_wb_access_ctrl (
      .clk_out      (clk_out),
      .core_rst_n_i (core_rst_n),
      .wb_cyc_i     (wb_cyc_i),
      .wb_stb_i     (wb_stb_i),
      .wb_we_i      (wb_we_i),
      .wb_adr_i     (wb_adr_i),
      .wb_dat_i     (wb_dat_i),
      .wb_dat_o     (wb_dat_o),
      .wb_ack_o     (wb_ack_o),
      .wb_err_o     (wb_err_o),
      .wr_done_i    (wr_done),
      .rd_done_i    (rd_done),
      .wr_rsp_i     (wr_rsp),
      .rd_rsp_i     (rd_rsp),
      .req_o        (req),
      .wr_start_o   (wr_start),
      .rd_start_o   (rd_start)
   );

   // --------------------------------------------------
   // CL side engines
   // --------------------------------------------------
   axi_wr_channel u_axi_wr_channel (
      .clk_out      (clk_out),
      .core_rst_n_i (core_rst_n),
      .req_i        (req),
      .start_i      (wr_start),
      .aw_o         (aw_o),
      .aw_valid_o   (aw_valid_o),
      .aw_ready_i   (aw_ready_i),
      .w_o          (w_o),
      .w_valid_o    (w_valid_o),
      .w_ready_i    (w_ready_i),
      .b_i          (b_i),
      .b_valid_i    (b_valid_i),
      .bready_o     (bready_o),
      .done_o       (wr_done),
      .rsp_o        (wr_rsp)
   );

   axi_rd_channel u_axi_rd_channel (
      .clk_out      (clk_out),
      .core_rst_n_i (core_rst_n),
      .req_i        (req),
      .start_i      (rd_start),
      .ar_o         (ar_o),
      .ar_valid_o   (ar_valid_o),
      .ar_ready_i   (ar_ready_i),
      .r_i          (r_i),
      .r_valid_i    (r_valid_i),
      .rready_o     (rready_o),
      .done_o       (rd_done),
      .rsp_o        (rd_rsp)
   );

endmodule

//--- test/cl_mem_model.sv
// behavioral AXI slave memory for the bridge testbench; byte store, random ready, error region
`timescale 1ns/1ps

module cl_mem_model
   import host_bridge_pkg::*;
#(
   parameter logic [31:0] SEED = 32'h1
) (
   input  logic    clk_out,
   input  logic    sync_rst_n,
   input  logic    bp_en_i,
   input  axi_aw_t aw_i,
   input  logic    aw_valid_i,
   output logic    aw_ready_o,
   input  axi_w_t  w_i,
   input  logic    w_valid_i,
   output logic    w_ready_o,
   output axi_b_t  b_o,
   output logic    b_valid_o,
   input  logic    bready_i,
   input  axi_ar_t ar_i,
   input  logic    ar_valid_i,
   output logic    ar_ready_o,
   output axi_r_t  r_o,
   output logic    r_valid_o,
   input  logic    rready_i
);

   localparam axi_resp_t RESP_SLVERR = 2'b10;

   logic [7:0] mem [axi_addr_t];
   axi_aw_t    aw_q;
   axi_w_t     w_q;
   axi_ar_t    ar_q;
   logic       have_aw;
   logic       have_w;
   logic       ar_hit;
   logic       b_hit;
   logic       r_hit;
   logic       err;
   axi_addr_t  base;

   // unwritten bytes read back as a fold of their address
   function automatic logic [7:0] fill_byte(input axi_addr_t a);
      logic [7:0] f;
      f = 8'h5a;
      for (int k = 0; k < 8; k++) begin
         f ^= a[k*8 +: 8];
      end
      return f;
   endfunction

   // --------------------------------------------------
   // slave process, outputs change 1 ns after the edge
   // --------------------------------------------------
   initial begin
      void'($urandom(SEED));
      aw_ready_o = 1'b0;
      w_ready_o  = 1'b0;
      ar_ready_o = 1'b0;
      b_valid_o  = 1'b0;
      r_valid_o  = 1'b0;
      b_o        = '0;
      r_o        = '0;
      have_aw    = 1'b0;
      have_w     = 1'b0;
      forever begin
         @(posedge clk_out);
         // transfers seen at this edge
         if (aw_valid_i && aw_ready_o) begin
            aw_q    = aw_i;
            have_aw = 1'b1;
         end
         if (w_valid_i && w_ready_o) begin
            w_q    = w_i;
            have_w = 1'b1;
         end
         ar_hit = ar_valid_i && ar_ready_o;
         if (ar_hit) begin
            ar_q = ar_i;
         end
         b_hit = b_valid_o && bready_i;
         r_hit = r_valid_o && rready_i;
         #1;
         if (!sync_rst_n) begin
            aw_ready_o = 1'b0;
            w_ready_o  = 1'b0;
            ar_ready_o = 1'b0;
            b_valid_o  = 1'b0;
            r_valid_o  = 1'b0;
            have_aw    = 1'b0;
            have_w     = 1'b0;
         end else begin
            if (b_hit) begin
               b_valid_o = 1'b0;
            end
            if (r_hit) begin
               r_valid_o = 1'b0;
            end
            // write lands once both address and data are in
            if (have_aw && have_w && !b_valid_o) begin
               base = {aw_q.addr[63:6], 6'b0};
               err  = |aw_q.addr[63:32];
               if (!err) begin
                  for (int i = 0; i < STRB_W; i++) begin
                     if (w_q.strb[i]) begin
                        mem[base + i] = w_q.data[i*8 +: 8];
                     end
                  end
               end
               b_o.id    = aw_q.id;
               b_o.resp  = err ? RESP_SLVERR : RESP_OKAY;
               b_valid_o = 1'b1;
               have_aw   = 1'b0;
               have_w    = 1'b0;
            end
            if (ar_hit) begin
               base = {ar_q.addr[63:6], 6'b0};
               err  = |ar_q.addr[63:32];
               for (int i = 0; i < STRB_W; i++) begin
                  if (err) begin
                     r_o.data[i*8 +: 8] = 8'h00;
                  end else if (mem.exists(base + i)) begin
                     r_o.data[i*8 +: 8] = mem[base + i];
                  end else begin
                     r_o.data[i*8 +: 8] = fill_byte(base + i);
                  end
               end
               r_o.id    = ar_q.id;
               r_o.resp  = err ? RESP_SLVERR : RESP_OKAY;
               r_o.last  = 1'b1;
               r_valid_o = 1'b1;
            end
            // back-pressure, a fresh coin per ready per cycle
            aw_ready_o = !bp_en_i || (($urandom % 2) == 1);
            w_ready_o  = !bp_en_i || (($urandom % 2) == 1);
            ar_ready_o = !bp_en_i || (($urandom % 2) == 1);
         end
      end
   end

endmodule

//--- test/tb_host_bridge.sv
// testbench top for the host bridge; runs the access table over Wishbone and checks each result
`timescale 1ns/1ps

module tb_host_bridge
   import host_bridge_pkg::*;
();

   localparam int NUM_ROWS   = 17;
   localparam int WB_TIMEOUT = 200;

   typedef struct packed {
      logic      write;
      axi_addr_t addr;
      word_t     data;
      logic      err;
   } row_t;

   logic      clk_out;
   logic      sync_rst_n;
   logic      flr_req;
   logic      calib_done;
   logic      bp_en;
   logic      wb_cyc;
   logic      wb_stb;
   logic      wb_we;
   axi_addr_t wb_adr;
   word_t     wb_dat;
   word_t     wb_rdat;
   logic      wb_ack;
   logic      wb_err;
   axi_aw_t   aw;
   logic      aw_valid;
   logic      aw_ready;
   axi_w_t    w;
   logic      w_valid;
   logic      w_ready;
   axi_b_t    b;
   logic      b_valid;
   logic      bready;
   axi_ar_t   ar;
   logic      ar_valid;
   logic      ar_ready;
   axi_r_t    r;
   logic      r_valid;
   logic      rready;
   logic      intf_rst_n;
   logic      ddr_ready;
   row_t      rows [NUM_ROWS];
   int        checks;
   int        errors;
   int        timeouts;

   host_bridge_top #(
      .RST_STAGES   (5),
      .READY_STAGES (3)
   ) dut (
      .clk_out      (clk_out),
      .sync_rst_n   (sync_rst_n),
      .flr_req_i    (flr_req),
      .calib_done_i (calib_done),
      .wb_cyc_i     (wb_cyc),
      .wb_stb_i     (wb_stb),
      .wb_we_i      (wb_we),
      .wb_adr_i     (wb_adr),
      .wb_dat_i     (wb_dat),
      .wb_dat_o     (wb_rdat),
      .wb_ack_o     (wb_ack),
      .wb_err_o     (wb_err),
      .aw_o         (aw),
      .aw_valid_o   (aw_valid),
      .aw_ready_i   (aw_ready),
      .w_o          (w),
      .w_valid_o    (w_valid),
      .w_ready_i    (w_ready),
      .b_i          (b),
      .b_valid_i    (b_valid),
      .bready_o     (bready),
      .ar_o         (ar),
      .ar_valid_o   (ar_valid),
      .ar_ready_i   (ar_ready),
      .r_i          (r),
      .r_valid_i    (r_valid),
      .rready_o     (rready),
      .intf_rst_n_o (intf_rst_n),
      .ddr_ready_o  (ddr_ready)
   );

   cl_mem_model #(
      .SEED (32'he105)
   ) u_cl_mem_model (
      .clk_out    (clk_out),
      .sync_rst_n (sync_rst_n),
      .bp_en_i    (bp_en),
      .aw_i       (aw),
      .aw_valid_i (aw_valid),
      .aw_ready_o (aw_ready),
      .w_i        (w),
      .w_valid_i  (w_valid),
      .w_ready_o  (w_ready),
      .b_o        (b),
      .b_valid_o  (b_valid),
      .bready_i   (bready),
      .ar_i       (ar),
      .ar_valid_i (ar_valid),
      .ar_ready_o (ar_ready),
      .r_o        (r),
      .r_valid_o  (r_valid),
      .rready_i   (rready)
   );

   initial begin
      clk_out = 1'b0;
      forever begin
         #2 clk_out = ~clk_out;
      end
   end

   // --------------------------------------------------
   // helpers
   // --------------------------------------------------
   function automatic row_t make_row(input logic wr, input axi_addr_t a, input word_t d,
                                     input logic e);
      row_t row;
      row.write = wr;
      row.addr  = a;
      row.data  = d;
      row.err   = e;
      return row;
   endfunction

   task check_value(input string name, input logic [63:0] exp, input logic [63:0] got);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("ERR %s exp %h got %h", name, exp, got);
      end
   endtask

   function logic status_bit(input int sel);
      case (sel)
         0:       return intf_rst_n;
         1:       return ddr_ready;
         default: return 1'b0;
      endcase
   endfunction

   task wait_status(input int sel, input logic level, input int limit, input string what);
      int n;
      n = 0;
      while (status_bit(sel) !== level && n < limit) begin
         @(posedge clk_out);
         #1;
         n++;
      end
      if (status_bit(sel) !== level) begin
         timeouts++;
         $display("timeout: %s did not reach %0d within %0d cycles", what, level, limit);
      end
   endtask

   // one Wishbone access, called 1 ns after a rising edge
   task run_row(input row_t row);
      int    n;
      logic  got_ack;
      logic  got_err;
      word_t got_dat;
      wb_cyc  = 1'b1;
      wb_stb  = 1'b1;
      wb_we   = row.write;
      wb_adr  = row.addr;
      wb_dat  = row.write ? row.data : '0;
      n       = 0;
      got_ack = 1'b0;
      got_err = 1'b0;
      while (!got_ack && !got_err && n < WB_TIMEOUT) begin
         @(posedge clk_out);
         #1;
         got_ack = wb_ack;
         got_err = wb_err;
         n++;
      end
      got_dat = wb_rdat;
      wb_cyc  = 1'b0;
      wb_stb  = 1'b0;
      wb_we   = 1'b0;
      if (!got_ack && !got_err) begin
         timeouts++;
         $display("timeout: no ack or err for access at address %h", row.addr);
      end else begin
         check_value("wb_ack_o", !row.err, got_ack);
         check_value("wb_err_o", row.err, got_err);
         if (!row.write && !row.err) begin
            check_value("wb_dat_o", row.data, got_dat);
         end
      end
      // ack or err lasts a single cycle
      @(posedge clk_out);
      #1;
      check_value("wb_ack_o|wb_err_o", 0, wb_ack | wb_err);
   endtask

   task load_rows();
      rows[0]  = make_row(1'b1, 64'h1000, 32'ha5a5_0001, 1'b0);
      rows[1]  = make_row(1'b0, 64'h1000, 32'ha5a5_0001, 1'b0);
      // several offsets of one line
      rows[2]  = make_row(1'b1, 64'h1044, 32'h1111_1111, 1'b0);
      rows[3]  = make_row(1'b1, 64'h1048, 32'h2222_2222, 1'b0);
      rows[4]  = make_row(1'b1, 64'h107c, 32'hffff_0015, 1'b0);
      rows[5]  = make_row(1'b1, 64'h1040, 32'h0000_0000, 1'b0);
      rows[6]  = make_row(1'b0, 64'h1044, 32'h1111_1111, 1'b0);
      rows[7]  = make_row(1'b0, 64'h1048, 32'h2222_2222, 1'b0);
      rows[8]  = make_row(1'b0, 64'h107c, 32'hffff_0015, 1'b0);
      // overwrite one offset, neighbors must survive
      rows[9]  = make_row(1'b1, 64'h1048, 32'h3333_3333, 1'b0);
      rows[10] = make_row(1'b0, 64'h1044, 32'h1111_1111, 1'b0);
      rows[11] = make_row(1'b0, 64'h1048, 32'h3333_3333, 1'b0);
      rows[12] = make_row(1'b0, 64'h1040, 32'h0000_0000, 1'b0);
      // low address bits are ignored
      rows[13] = make_row(1'b0, 64'h107f, 32'hffff_0015, 1'b0);
      // error region, upper half of the address nonzero
      rows[14] = make_row(1'b1, 64'h1_0000_0010, 32'hbad0_0001, 1'b1);
      rows[15] = make_row(1'b0, 64'h1_0000_0010, 32'h0000_0000, 1'b1);
      rows[16] = make_row(1'b0, 64'h1000, 32'ha5a5_0001, 1'b0);
   endtask

   // --------------------------------------------------
   // AXI command fields sampled mid-cycle
   // --------------------------------------------------
   // single-beat bursts with id zero
   initial begin
      forever begin
         @(negedge clk_out);
         if (aw_valid === 1'b1) begin
            check_value("aw_o.id", 0, aw.id);
            check_value("aw_o.len", 0, aw.len);
         end
         if (w_valid === 1'b1) begin
            check_value("w_o.last", 1, w.last);
         end
         if (ar_valid === 1'b1) begin
            check_value("ar_o.id", 0, ar.id);
            check_value("ar_o.len", 0, ar.len);
         end
      end
   end

   // --------------------------------------------------
   // main sequence
   // --------------------------------------------------
   initial begin
      sync_rst_n = 1'b0;
      flr_req    = 1'b0;
      // calibration flag high while reset holds ddr_ready_o low
      calib_done = 1'b1;
      bp_en      = 1'b0;
      wb_cyc     = 1'b0;
      wb_stb     = 1'b0;
      wb_we      = 1'b0;
      wb_adr     = '0;
      wb_dat     = '0;
      checks     = 0;
      errors     = 0;
      timeouts   = 0;
      load_rows();
      repeat (3) @(posedge clk_out);
      #1;
      check_value("aw_valid_o", 0, aw_valid);
      check_value("w_valid_o", 0, w_valid);
      check_value("ar_valid_o", 0, ar_valid);
      check_value("bready_o", 0, bready);
      check_value("rready_o", 0, rready);
      check_value("wb_ack_o", 0, wb_ack);
      check_value("wb_err_o", 0, wb_err);
      check_value("intf_rst_n_o", 0, intf_rst_n);
      check_value("ddr_ready_o", 0, ddr_ready);
      sync_rst_n = 1'b1;
      calib_done = 1'b0;
      wait_status(0, 1'b1, 20, "intf_rst_n_o");
      // first pass with ready always high, second with random back-pressure
      for (int pass = 0; pass < 2; pass++) begin
         bp_en = (pass == 1);
         for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(rows[i]);
         end
      end
      bp_en = 1'b0;
      check_value("ddr_ready_o", 0, ddr_ready);
      calib_done = 1'b1;
      wait_status(1, 1'b1, 10, "ddr_ready_o");
      flr_req = 1'b1;
      wait_status(0, 1'b0, 5, "intf_rst_n_o");
      flr_req = 1'b0;
      wait_status(0, 1'b1, 5, "intf_rst_n_o");
      $display("checks %0d errors %0d timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- filelist.f
source/host_bridge_pkg.sv
source/reset_ctrl.sv
source/wb_access_ctrl.sv
source/axi_wr_channel.sv
source/axi_rd_channel.sv
source/host_bridge_top.sv
test/cl_mem_model.sv
test/tb_host_bridge.sv
